// ==== hdl/ctrl_regs.sv ====
module ctrl_regs
    import mem_pkg::*;
#(
    parameter int DATA_WID = 32
) (
    input  logic        clk,
    input  logic        rst_n,

    mem_intf.peripheral bus
);

    logic [DATA_WID-1:0] scratch;
    logic [DATA_WID-1:0] wr_count;
    logic [DATA_WID-1:0] rd_word;
    reg_offset_e         offset;
    logic                in_range;
    logic                do_wr;
    logic                do_rd;

    assign bus.rdy = 1'b1;

    assign offset   = reg_offset_e'(bus.addr[1:0]);
    assign in_range = (bus.addr >> 2) == '0;  // only the first few words decode
    assign do_wr    = bus.req && bus.rdy && bus.wr;
    assign do_rd    = bus.req && bus.rdy && !bus.wr;

    always_comb begin
        rd_word = '0;
        if (in_range) begin
            case (offset)
                REG_ID:       rd_word = DATA_WID'(REGS_ID);
                REG_SCRATCH:  rd_word = scratch;
                REG_WR_COUNT: rd_word = wr_count;
                default:      rd_word = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch    <= '0;
            wr_count   <= '0;
            bus.wr_ack <= 1'b0;
            bus.rd_ack <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_count <= wr_count + 1'b1;  // any offset counts
                if (in_range && offset == REG_SCRATCH) begin
                    scratch <= bus.wr_data;
                end
            end
            bus.wr_ack <= do_wr;
            bus.rd_ack <= do_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            bus.rd_data <= rd_word;
        end
    end

endmodule : ctrl_regs

// ==== hdl/mem_decoder.sv ====
module mem_decoder
    import mem_pkg::*;
#(
    parameter int ADDR_WID = 8
) (
    input  logic        clk,
    input  logic        rst_n,

    mem_intf.peripheral host,
    mem_intf.controller sram,
    mem_intf.controller regs
);

    periph_sel_e sel_req;   // target of the incoming request
    periph_sel_e pend_sel;  // target of the outstanding one
    logic        pending;
    logic        accept;
    logic        resp;

    assign sel_req = periph_sel_e'(host.addr[ADDR_WID-1]);

    assign host.rdy = !pending && ((sel_req == SEL_SRAM) ? sram.rdy : regs.rdy);
    assign accept   = host.req && host.rdy;

    // only the selected side sees req
    assign sram.req     = host.req && !pending && (sel_req == SEL_SRAM);
    assign sram.wr      = host.wr;
    assign sram.addr    = host.addr[ADDR_WID-2:0];
    assign sram.wr_data = host.wr_data;

    assign regs.req     = host.req && !pending && (sel_req == SEL_REGS);
    assign regs.wr      = host.wr;
    assign regs.addr    = host.addr[ADDR_WID-2:0];
    assign regs.wr_data = host.wr_data;

    // response from whichever target owns the transaction
    always_comb begin
        if (pend_sel == SEL_SRAM) begin
            host.wr_ack  = pending && sram.wr_ack;
            host.rd_ack  = pending && sram.rd_ack;
            host.rd_data = sram.rd_data;
        end else begin
            host.wr_ack  = pending && regs.wr_ack;
            host.rd_ack  = pending && regs.rd_ack;
            host.rd_data = regs.rd_data;
        end
    end

    assign resp = host.wr_ack || host.rd_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= 1'b0;
            pend_sel <= SEL_SRAM;
        end else if (accept) begin
            pending  <= 1'b1;
            pend_sel <= sel_req;
        end else if (resp) begin
            pending  <= 1'b0;  // next request may go
        end
    end

endmodule : mem_decoder

// ==== hdl/mem_intf.sv ====
interface mem_intf #(
    parameter int ADDR_WID = 8,
    parameter int DATA_WID = 32
) ();

    logic                rdy;      // peripheral can take a request
    logic                req;
    logic                wr;       // 1 = write, 0 = read
    logic [ADDR_WID-1:0] addr;
    logic [DATA_WID-1:0] wr_data;
    logic                wr_ack;   // one-cycle pulse per accepted write
    logic [DATA_WID-1:0] rd_data;  // valid with rd_ack
    logic                rd_ack;

    // side that issues transactions
    modport controller(
        input  rdy,
        output req,
        output wr,
        output addr,
        output wr_data,
        input  wr_ack,
        input  rd_data,
        input  rd_ack
    );

    // side that serves them
    modport peripheral(
        output rdy,
        input  req,
        input  wr,
        input  addr,
        input  wr_data,
        output wr_ack,
        output rd_data,
        output rd_ack
    );

endinterface : mem_intf

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

    // wishbone bridge sequencing
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_REQ,
        BR_WAIT,
        BR_ACK
    } bridge_state_e;

    // target picked by the top address bit
    typedef enum logic {
        SEL_SRAM,
        SEL_REGS
    } periph_sel_e;

    // word offsets inside the register block
    typedef enum logic [1:0] {
        REG_ID       = 2'd0,
        REG_SCRATCH  = 2'd1,
        REG_WR_COUNT = 2'd2
    } reg_offset_e;

    localparam logic [31:0] REGS_ID = 32'h4d53_0101;  // read-only block identifier

endpackage : mem_pkg

// ==== hdl/mem_subsys_top.sv ====
module mem_subsys_top #(
    parameter int ADDR_WID  = 8,
    parameter int DATA_WID  = 32,
    parameter int RAM_DEPTH = 64
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [ADDR_WID-1:0] adr,
    input  logic [DATA_WID-1:0] dat_w,
    output logic [DATA_WID-1:0] dat_r,
    output logic                ack
);

    mem_intf #(.ADDR_WID(ADDR_WID),   .DATA_WID(DATA_WID)) bus_if ();
    mem_intf #(.ADDR_WID(ADDR_WID-1), .DATA_WID(DATA_WID)) sram_if ();  // top bit decoded away
    mem_intf #(.ADDR_WID(ADDR_WID-1), .DATA_WID(DATA_WID)) regs_if ();

    wb_mem_bridge #(
        .ADDR_WID(ADDR_WID),
        .DATA_WID(DATA_WID)
    ) i_wb_mem_bridge (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .mem   (bus_if.controller)
    );

    mem_decoder #(
        .ADDR_WID(ADDR_WID)
    ) i_mem_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .host  (bus_if.peripheral),
        .sram  (sram_if.controller),
        .regs  (regs_if.controller)
    );

    sram_periph #(
        .DATA_WID (DATA_WID),
        .RAM_DEPTH(RAM_DEPTH)
    ) i_sram_periph (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (sram_if.peripheral)
    );

    ctrl_regs #(
        .DATA_WID(DATA_WID)
    ) i_ctrl_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (regs_if.peripheral)
    );

endmodule : mem_subsys_top

// ==== hdl/sram_periph.sv ====
module sram_periph #(
    parameter int DATA_WID  = 32,
    parameter int RAM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst_n,

    mem_intf.peripheral bus
);

    localparam int IDX_WID = $clog2(RAM_DEPTH);

    logic [DATA_WID-1:0] mem [RAM_DEPTH];
    logic [IDX_WID-1:0]  idx;
    logic                do_wr;
    logic                do_rd;

    assign bus.rdy = 1'b1;  // never stalls

    assign idx   = bus.addr[IDX_WID-1:0];  // upper bits alias
    assign do_wr = bus.req && bus.rdy && bus.wr;
    assign do_rd = bus.req && bus.rdy && !bus.wr;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[idx] <= bus.wr_data;
        end
        if (do_rd) begin
            bus.rd_data <= mem[idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.wr_ack <= 1'b0;
            bus.rd_ack <= 1'b0;
        end else begin
            bus.wr_ack <= do_wr;
            bus.rd_ack <= do_rd;
        end
    end

endmodule : sram_periph

// ==== hdl/wb_mem_bridge.sv ====
module wb_mem_bridge
    import mem_pkg::*;
#(
    parameter int ADDR_WID = 8,
    parameter int DATA_WID = 32
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [ADDR_WID-1:0] adr,
    input  logic [DATA_WID-1:0] dat_w,
    output logic [DATA_WID-1:0] dat_r,
    output logic                ack,

    mem_intf.controller         mem
);

    bridge_state_e       state;
    logic [ADDR_WID-1:0] adr_q;
    logic [DATA_WID-1:0] dat_q;
    logic                we_q;
    logic                resp;

    assign resp = mem.wr_ack | mem.rd_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BR_IDLE;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (cyc && stb) begin
                        state <= BR_REQ;
                    end
                end
                BR_REQ: begin
                    if (mem.rdy) begin
                        state <= BR_WAIT;  // accepted this cycle
                    end
                end
                BR_WAIT: begin
                    if (resp) begin
                        state <= BR_ACK;
                    end
                end
                default: begin
                    state <= BR_IDLE;  // ack cycle done
                end
            endcase
        end
    end

    // latch the request at the start of the bus cycle
    always_ff @(posedge clk) begin
        if (state == BR_IDLE && cyc && stb) begin
            adr_q <= adr;
            dat_q <= dat_w;
            we_q  <= we;
        end
        if (state == BR_WAIT && mem.rd_ack) begin
            dat_r <= mem.rd_data;
        end
    end

    assign mem.req     = (state == BR_REQ);
    assign mem.wr      = we_q;
    assign mem.addr    = adr_q;
    assign mem.wr_data = dat_q;

    assign ack = (state == BR_ACK);  // single cycle

endmodule : wb_mem_bridge

// ==== mem_subsys.f ====
hdl/mem_pkg.sv
hdl/mem_intf.sv
hdl/wb_mem_bridge.sv
hdl/mem_decoder.sv
hdl/sram_periph.sv
hdl/ctrl_regs.sv
hdl/mem_subsys_top.sv
verification/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb \
    -f mem_subsys.f -o mem_subsys_sim || { echo "build failed"; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== verification/mem_subsys_tb.sv ====
module mem_subsys_tb
    import mem_pkg::*;
();

    localparam int ADDR_WID   = 8;
    localparam int DATA_WID   = 32;
    localparam int RAM_DEPTH  = 64;
    localparam int TXN_CYCLES = 20;               // ack limit per bus cycle
    localparam int MAX_CYCLES = 180 * TXN_CYCLES;  // about 180 bus cycles in all tests

    logic                clk = 1'b0;
    logic                rst_n, cyc, stb, we, ack, ack_prev;
    logic [ADDR_WID-1:0] adr;
    logic [DATA_WID-1:0] dat_w, dat_r;
    logic [DATA_WID-1:0] ram_model [RAM_DEPTH];
    logic [DATA_WID-1:0] scratch_model, count_model;
    int                  errors = 0, txns = 0, acks = 0, cycles = 0;
    int                  seed = 79;

    mem_subsys_top #(
        .ADDR_WID (ADDR_WID),
        .DATA_WID (DATA_WID),
        .RAM_DEPTH(RAM_DEPTH)
    ) i_mem_subsys_top (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("errors: %0d  transactions: %0d  acks: %0d", errors, txns, acks);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ack protocol watch
    always @(negedge clk) begin
        if (rst_n) begin
            if (ack) begin
                acks++;
                assert (stb) else begin
                    errors++;
                    $display("ack was raised while stb was low");
                end
                assert (!ack_prev) else begin
                    errors++;
                    $display("ack stayed high for more than one cycle");
                end
            end
            ack_prev <= ack;
        end
    end

    function automatic logic [ADDR_WID-1:0] reg_addr(input reg_offset_e off);
        return {1'b1, {(ADDR_WID-3){1'b0}}, 2'(off)};
    endfunction

    // expected read value from the register map and the RAM mirror
    function automatic logic [DATA_WID-1:0] expected_read(input logic [ADDR_WID-1:0] addr);
        logic [ADDR_WID-2:0] off;
        off = addr[ADDR_WID-2:0];
        if (periph_sel_e'(addr[ADDR_WID-1]) == SEL_SRAM) return ram_model[addr % RAM_DEPTH];
        if (off == 7'(REG_ID)) return REGS_ID;
        if (off == 7'(REG_SCRATCH)) return scratch_model;
        if (off == 7'(REG_WR_COUNT)) return count_model;
        return '0;
    endfunction

    task automatic bus_cycle(input logic write, input logic [ADDR_WID-1:0] addr,
                             input logic [DATA_WID-1:0] wdata,
                             output logic [DATA_WID-1:0] rdata);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= addr;
        dat_w <= wdata;
        txns++;
        while (!got_ack && waited < TXN_CYCLES) begin
            @(negedge clk);
            waited++;
            got_ack = ack;
        end
        rdata = dat_r;
        assert (got_ack) else begin
            errors++;
            $display("no ack within %0d cycles for address %h", TXN_CYCLES, addr);
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [ADDR_WID-1:0] addr, input logic [DATA_WID-1:0] data,
                            input bit hold = 0);
        logic [DATA_WID-1:0] unused;
        bus_cycle(1'b1, addr, data, unused);
        if (periph_sel_e'(addr[ADDR_WID-1]) == SEL_SRAM) begin
            ram_model[addr % RAM_DEPTH] = data;
        end else begin
            count_model++;  // every register-side write counts
            if (addr[ADDR_WID-2:0] == 7'(REG_SCRATCH)) scratch_model = data;
        end
        if (!hold) release_bus();
    endtask

    task automatic wb_read(input logic [ADDR_WID-1:0] addr, input bit hold = 0);
        logic [DATA_WID-1:0] got, exp;
        exp = expected_read(addr);
        bus_cycle(1'b0, addr, '0, got);
        assert (got === exp) else begin
            errors++;
            $display("mismatch dat_r at adr %h: got %h expected %h", addr, got, exp);
        end
        if (!hold) release_bus();
    endtask

    task automatic reset_values();
        assert (ack === 1'b0) else begin
            errors++;
            $display("mismatch ack: got %h expected %h", ack, 1'b0);
        end
        wb_read(reg_addr(REG_ID));
        wb_read(reg_addr(REG_SCRATCH));
        wb_read(reg_addr(REG_WR_COUNT));
    endtask

    task automatic ram_fill_readback();
        int order [RAM_DEPTH];
        int j, tmp;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            wb_write(ADDR_WID'(i), $random(seed));
            order[i] = i;
        end
        for (int i = RAM_DEPTH - 1; i > 0; i--) begin  // shuffle readback order
            j        = int'({$random(seed)} % (i + 1));
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < RAM_DEPTH; i++) wb_read(ADDR_WID'(order[i]));
    endtask

    task automatic scratch_access();
        for (int i = 0; i < 3; i++) begin
            wb_write(reg_addr(REG_SCRATCH), $random(seed));
            wb_read(reg_addr(REG_SCRATCH));
        end
        wb_write(reg_addr(REG_ID), 32'hffff_ffff);  // read-only but counted
        wb_read(reg_addr(REG_ID));
    endtask

    task automatic write_counting();
        wb_read(reg_addr(REG_WR_COUNT));
        wb_write(reg_addr(REG_WR_COUNT), 32'h0000_1234);
        wb_write(8'h10, $random(seed));
        wb_read(reg_addr(REG_WR_COUNT));
    endtask

    task automatic half_isolation();
        wb_read(8'h83);
        wb_read(8'h84);
        wb_read(8'hff);
        wb_write(8'h91, 32'hdead_beef);  // unmapped register word
        wb_write(8'h05, $random(seed));
        wb_read(reg_addr(REG_SCRATCH));
        wb_read(reg_addr(REG_WR_COUNT));
        wb_write(reg_addr(REG_SCRATCH), $random(seed));
        wb_read(8'h05);
        wb_read(8'h45);  // aliases word 5
    endtask

    task automatic back_to_back_cycles();
        for (int i = 0; i < 6; i++) begin
            wb_write(ADDR_WID'(8'h20 + i), $random(seed), 1);
            wb_read(reg_addr(REG_WR_COUNT), 1);
        end
        for (int i = 0; i < 6; i++) begin
            wb_read(ADDR_WID'(8'h20 + i), 1);
            wb_write(reg_addr(REG_SCRATCH), $random(seed), i < 5);
        end
        wb_read(reg_addr(REG_SCRATCH));
    endtask

    initial begin
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        ack_prev = 1'b0;
        scratch_model = '0;
        count_model = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_values();
        ram_fill_readback();
        scratch_access();
        write_counting();
        half_isolation();
        back_to_back_cycles();
        repeat (3) @(posedge clk);
        assert (acks == txns) else begin
            errors++;
            $display("mismatch ack count: got %h expected %h", acks, txns);
        end
        $display("errors: %0d  transactions: %0d  acks: %0d", errors, txns, acks);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : mem_subsys_tb
